/* rtl/x86_isa_pkg.sv */
`default_nettype none

package x86_isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;

    // Register number in x86 order, AX CX DX BX SP BP SI DI
    typedef logic [2:0] reg_idx_t;

    localparam reg_idx_t REG_AX = 3'd0;

    // Kept subset of the flags register
    typedef struct packed {
        logic of;
        logic sf;
        logic zf;
        logic cf;
    } flags_t;

    // Codes 0, 1 and 4 to 7 equal opcode bits 5:3 of the 00-3F group.
    // 2 and 3 are ADC and SBB there, which are not kept, so MOV reuses 2
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_OR  = 3'd1,
        ALU_MOV = 3'd2,
        ALU_AND = 3'd4,
        ALU_SUB = 3'd5,
        ALU_XOR = 3'd6,
        ALU_CMP = 3'd7
    } alu_op_t;

    // MOV r16, imm16 occupies B8 to BF, low bits give the register
    localparam byte_t OPC_MOV_IMM = 8'hB8;

    // MOV r/m16, r16 and MOV r16, r/m16
    localparam byte_t OPC_MOV_RM = 8'h89;
    localparam byte_t OPC_MOV_R  = 8'h8B;

    // Opcode bits inside the 00-3F group
    localparam int OPC_WORD_BIT = 0;
    localparam int OPC_DIR_BIT  = 1;
    localparam int OPC_IMM_BIT  = 2;
    localparam int OPC_SEL_LSB  = 3;

    // ModRM mod field value for a register operand
    localparam logic [1:0] MOD_REG = 2'b11;

endpackage

`default_nettype wire

/* rtl/core_uarch_pkg.sv */
`default_nettype none

package core_uarch_pkg;

    localparam int BYTE_FIFO_DEPTH = 8;
    localparam int RES_FIFO_DEPTH  = 4;

    // Records the sink can hold
    localparam int RES_CREDITS = 4;

    // Occupancy counter widths of the two queues
    localparam int BYTE_CNT_W = $clog2(BYTE_FIFO_DEPTH + 1);
    localparam int RES_CNT_W  = $clog2(RES_FIFO_DEPTH + 1);

    // Holds up to 8
    typedef logic [3:0] credit_cnt_t;

    typedef struct packed {
        x86_isa_pkg::reg_idx_t rreg;
        x86_isa_pkg::word_t    value;
        x86_isa_pkg::flags_t   flags;
    } retire_rec_t;

endpackage

`default_nettype wire

/* rtl/credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  payload_t                     push_data,
    input  logic                         pop,
    output payload_t                     pop_data,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              do_push;
    logic              do_pop;

    assign do_push = push && (count != CNT_W'(DEPTH));
    assign do_pop  = pop && !empty;

    assign empty    = (count == '0);
    // Head entry is visible without a pop
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/insn_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  x86_isa_pkg::byte_t     byte_in,
    input  logic                   empty,
    input  logic                   room,
    output logic                   pop,
    output logic                   issue,
    output x86_isa_pkg::alu_op_t   op,
    output x86_isa_pkg::reg_idx_t  dst,
    output x86_isa_pkg::reg_idx_t  src,
    output logic                   use_imm,
    output x86_isa_pkg::word_t     imm,
    output logic                   write_back
);

    import x86_isa_pkg::*;

    typedef enum logic [1:0] {
        S_OPCODE,
        S_MODRM,
        S_IMM_LO,
        S_IMM_HI
    } state_t;

    state_t   state;
    state_t   state_next;
    logic     issue_next;
    logic     dir_q;
    logic     alu_grp;
    logic     is_acc_imm;
    logic     is_alu_rr;
    logic     is_mov_rr;
    logic     is_mov_imm;
    alu_op_t  opc_op;
    reg_idx_t modrm_reg;
    reg_idx_t modrm_rm;
    logic     modrm_is_reg;

    // Every state takes exactly one byte
    assign pop = !empty && room;

    // 00-3F group without ADC and SBB
    assign alu_grp    = (byte_in[7:6] == 2'b00) && (byte_in[5:4] != 2'b01);
    assign is_acc_imm = alu_grp && byte_in[OPC_IMM_BIT] && !byte_in[OPC_DIR_BIT]
                        && byte_in[OPC_WORD_BIT];
    assign is_alu_rr  = alu_grp && !byte_in[OPC_IMM_BIT] && byte_in[OPC_WORD_BIT];
    assign is_mov_rr  = (byte_in == OPC_MOV_RM) || (byte_in == OPC_MOV_R);
    assign is_mov_imm = (byte_in[7:3] == OPC_MOV_IMM[7:3]);

    assign opc_op = (is_mov_rr || is_mov_imm) ? ALU_MOV
                                              : alu_op_t'(byte_in[OPC_SEL_LSB +: 3]);

    assign modrm_reg    = byte_in[5:3];
    assign modrm_rm     = byte_in[2:0];
    assign modrm_is_reg = (byte_in[7:6] == MOD_REG);

    always_comb begin
        state_next = state;
        issue_next = 1'b0;
        if (pop) begin
            case (state)
                S_OPCODE: begin
                    if (is_mov_imm || is_acc_imm) begin
                        state_next = S_IMM_LO;
                    end else if (is_alu_rr || is_mov_rr) begin
                        state_next = S_MODRM;
                    end
                end
                S_MODRM: begin
                    // Memory forms are dropped here
                    state_next = S_OPCODE;
                    issue_next = modrm_is_reg;
                end
                S_IMM_LO: state_next = S_IMM_HI;
                default: begin
                    state_next = S_OPCODE;
                    issue_next = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_OPCODE;
            issue <= 1'b0;
        end else begin
            state <= state_next;
            issue <= issue_next;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            case (state)
                S_OPCODE: begin
                    op         <= opc_op;
                    use_imm    <= is_mov_imm || is_acc_imm;
                    dst        <= is_mov_imm ? byte_in[2:0] : REG_AX;
                    dir_q      <= byte_in[OPC_DIR_BIT];
                    write_back <= (opc_op != ALU_CMP);
                end
                S_MODRM: begin
                    dst <= dir_q ? modrm_reg : modrm_rm;
                    src <= dir_q ? modrm_rm : modrm_reg;
                end
                S_IMM_LO: imm[7:0] <= byte_in;
                default:  imm[15:8] <= byte_in;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/alu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        issue,
    input  x86_isa_pkg::alu_op_t        op,
    input  x86_isa_pkg::reg_idx_t       dst,
    input  x86_isa_pkg::reg_idx_t       src,
    input  logic                        use_imm,
    input  x86_isa_pkg::word_t          imm,
    input  logic                        write_back,
    output logic                        push,
    output core_uarch_pkg::retire_rec_t push_rec
);

    import x86_isa_pkg::*;

    word_t       regs [8];
    flags_t      flags_q;
    word_t       a;
    word_t       b;
    logic [16:0] sum;
    logic [16:0] diff;
    word_t       result;
    flags_t      flags_next;

    assign a    = regs[dst];
    assign b    = use_imm ? imm : regs[src];
    assign sum  = {1'b0, a} + {1'b0, b};
    // Bit 16 is the borrow
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb begin
        result     = b;
        flags_next = flags_q;
        case (op)
            ALU_ADD: begin
                result        = sum[15:0];
                flags_next.cf = sum[16];
                flags_next.of = (a[15] == b[15]) && (sum[15] != a[15]);
            end
            ALU_SUB, ALU_CMP: begin
                result        = diff[15:0];
                flags_next.cf = diff[16];
                flags_next.of = (a[15] != b[15]) && (diff[15] != a[15]);
            end
            ALU_AND: begin
                result        = a & b;
                flags_next.cf = 1'b0;
                flags_next.of = 1'b0;
            end
            ALU_OR: begin
                result        = a | b;
                flags_next.cf = 1'b0;
                flags_next.of = 1'b0;
            end
            ALU_XOR: begin
                result        = a ^ b;
                flags_next.cf = 1'b0;
                flags_next.of = 1'b0;
            end
            default: result = b;
        endcase
        // MOV leaves all flags alone
        if (op != ALU_MOV) begin
            flags_next.zf = (result == '0);
            flags_next.sf = result[15];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            flags_q <= '0;
        end else if (issue) begin
            if (write_back) begin
                regs[dst] <= result;
            end
            flags_q <= flags_next;
        end
    end

    // Record goes into the retire queue at the same edge as the write
    assign push           = issue;
    assign push_rec.rreg  = dst;
    assign push_rec.value = write_back ? result : a;
    assign push_rec.flags = flags_next;

endmodule

`default_nettype wire

/* rtl/retire_result.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_result (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  core_uarch_pkg::retire_rec_t push_rec,
    input  logic                        res_credit,
    output logic                        room,
    output logic                        res_valid,
    output x86_isa_pkg::reg_idx_t       res_reg,
    output x86_isa_pkg::word_t          res_value,
    output x86_isa_pkg::flags_t         res_flags
);

    import core_uarch_pkg::*;

    retire_rec_t          head_rec;
    logic                 res_empty;
    logic [RES_CNT_W-1:0] res_count;
    credit_cnt_t          credit_cnt;
    logic                 res_pop;

    credit_fifo #(
        .payload_t (retire_rec_t),
        .DEPTH     (RES_FIFO_DEPTH)
    ) u_res_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_rec),
        .pop       (res_pop),
        .pop_data  (head_rec),
        .empty     (res_empty),
        .count     (res_count)
    );

    // Keep one slot free for an issue already under way
    assign room = (res_count < RES_CNT_W'(RES_FIFO_DEPTH - 1));

    assign res_pop   = !res_empty && (credit_cnt != '0);
    assign res_valid = res_pop;
    assign res_reg   = head_rec.rreg;
    assign res_value = head_rec.value;
    assign res_flags = head_rec.flags;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= credit_cnt_t'(RES_CREDITS);
        end else begin
            case ({res_pop, res_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  x86_isa_pkg::byte_t    in_byte,
    output logic                  in_credit,
    output logic                  res_valid,
    output x86_isa_pkg::reg_idx_t res_reg,
    output x86_isa_pkg::word_t    res_value,
    output x86_isa_pkg::flags_t   res_flags,
    input  logic                  res_credit
);

    import x86_isa_pkg::*;
    import core_uarch_pkg::*;

    byte_t                 byte_q;
    logic                  byte_empty;
    logic [BYTE_CNT_W-1:0] byte_count;
    logic                  byte_pop;
    logic                  room;
    logic                  issue;
    alu_op_t               op;
    reg_idx_t              dst;
    reg_idx_t              src;
    logic                  use_imm;
    word_t                 imm;
    logic                  write_back;
    logic                  push;
    retire_rec_t           push_rec;

    // Each byte leaving the queue hands a credit back to the sender
    assign in_credit = byte_pop;

    credit_fifo #(
        .payload_t (byte_t),
        .DEPTH     (BYTE_FIFO_DEPTH)
    ) u_byte_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (in_byte),
        .pop       (byte_pop),
        .pop_data  (byte_q),
        .empty     (byte_empty),
        .count     (byte_count)
    );

    insn_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_in    (byte_q),
        .empty      (byte_empty),
        .room       (room),
        .pop        (byte_pop),
        .issue      (issue),
        .op         (op),
        .dst        (dst),
        .src        (src),
        .use_imm    (use_imm),
        .imm        (imm),
        .write_back (write_back)
    );

    alu_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue),
        .op         (op),
        .dst        (dst),
        .src        (src),
        .use_imm    (use_imm),
        .imm        (imm),
        .write_back (write_back),
        .push       (push),
        .push_rec   (push_rec)
    );

    retire_result u_retire (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_rec   (push_rec),
        .res_credit (res_credit),
        .room       (room),
        .res_valid  (res_valid),
        .res_reg    (res_reg),
        .res_value  (res_value),
        .res_flags  (res_flags)
    );

endmodule

`default_nettype wire

/* verification/core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module core_asserts (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  logic [core_uarch_pkg::BYTE_CNT_W-1:0] byte_count,
    input  logic                                 res_valid,
    input  logic                                 res_credit,
    input  logic                                 issue,
    input  logic                                 room
);

    import core_uarch_pkg::*;

    // Credits the core may still spend, tracked from the port pulses alone
    credit_cnt_t out_credits;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_credits <= credit_cnt_t'(RES_CREDITS);
        end else begin
            out_credits <= out_credits + credit_cnt_t'(res_credit) - credit_cnt_t'(res_valid);
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (byte_count != BYTE_CNT_W'(BYTE_FIFO_DEPTH)))
        else $error("byte queue written while full");

    a_valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (out_credits != '0))
        else $error("result presented with no output credit");

    a_issue_needs_room: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> room)
        else $error("issue while the retire queue had no room");

endmodule

bind core_top core_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .byte_count (byte_count),
    .res_valid  (res_valid),
    .res_credit (res_credit),
    .issue      (issue),
    .room       (room)
);

`default_nettype wire

/* verification/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    import x86_isa_pkg::*;
    import core_uarch_pkg::*;

    localparam int      CLK_HALF        = 4;
    localparam int      CYCLES_PER_BYTE = 20;
    localparam int      WATCHDOG_MARGIN = 400;
    localparam int      RAND_INSNS      = 48;
    localparam byte_t   MOV_IMM_BASE    = 8'hB8;
    localparam alu_op_t OPS [7] = '{ALU_ADD, ALU_OR, ALU_AND, ALU_SUB, ALU_XOR, ALU_CMP,
                                    ALU_MOV};

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    byte_t    in_byte;
    logic     in_credit;
    logic     res_valid;
    reg_idx_t res_reg;
    word_t    res_value;
    flags_t   res_flags;
    logic     res_credit;

    // Reference model state
    word_t    m_regs [8];
    flags_t   m_flags;

    byte_t    tx_q [$];
    reg_idx_t exp_reg [$];
    word_t    exp_value [$];
    flags_t   exp_flags [$];

    int tx_credits;
    int sink_held;
    bit sink_random;
    int bytes_sent;
    int mismatches;
    int other_errors;

    core_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_byte    (in_byte),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res_reg    (res_reg),
        .res_value  (res_value),
        .res_flags  (res_flags),
        .res_credit (res_credit)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic compare_reg(input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: register got %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic compare_value(input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: value got %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_flags(input flags_t got, input flags_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: flags (of sf zf cf) got %b, expected %b",
                     $time, got, exp);
        end
    endtask

    // Applies one instruction to the model and queues the record it must retire
    task automatic model_exec(input alu_op_t op, input reg_idx_t d, input word_t b);
        word_t       a;
        word_t       r;
        flags_t      f;
        int unsigned wide;
        int          s_wide;
        logic signed [15:0] sa;
        logic signed [15:0] sb;
        a  = m_regs[d];
        sa = a;
        sb = b;
        f  = m_flags;
        s_wide = 0;
        case (op)
            ALU_ADD: begin
                wide   = 32'(a) + 32'(b);
                s_wide = int'(sa) + int'(sb);
                r      = wide[15:0];
                f.cf   = (wide > 32'hFFFF);
            end
            ALU_SUB, ALU_CMP: begin
                s_wide = int'(sa) - int'(sb);
                r      = a - b;
                f.cf   = (a < b);
            end
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            default: r = b;
        endcase
        if (op inside {ALU_ADD, ALU_SUB, ALU_CMP}) begin
            f.of = (s_wide > 32767) || (s_wide < -32768);
        end
        if (op inside {ALU_AND, ALU_OR, ALU_XOR}) begin
            f.cf = 1'b0;
            f.of = 1'b0;
        end
        if (op != ALU_MOV) begin
            f.zf = (r == 16'h0000);
            f.sf = r[15];
        end
        if (op != ALU_CMP) begin
            m_regs[d] = r;
        end
        m_flags = f;
        exp_reg.push_back(d);
        exp_value.push_back(m_regs[d]);
        exp_flags.push_back(f);
    endtask

    function automatic byte_t alu_opcode(input alu_op_t op);
        case (op)
            ALU_ADD: return 8'h01;
            ALU_OR:  return 8'h09;
            ALU_AND: return 8'h21;
            ALU_SUB: return 8'h29;
            ALU_XOR: return 8'h31;
            ALU_CMP: return 8'h39;
            default: return 8'h89;
        endcase
    endfunction

    task automatic queue_byte(input byte_t b);
        tx_q.push_back(b);
        bytes_sent++;
    endtask

    task automatic send_rr(input alu_op_t op, input bit dir, input reg_idx_t d,
                           input reg_idx_t s);
        queue_byte(alu_opcode(op) | (dir ? 8'h02 : 8'h00));
        queue_byte(dir ? {2'b11, d, s} : {2'b11, s, d});
        model_exec(op, d, m_regs[s]);
    endtask

    task automatic send_acc(input alu_op_t op, input word_t imm);
        queue_byte(alu_opcode(op) + 8'h04);
        queue_byte(imm[7:0]);
        queue_byte(imm[15:8]);
        model_exec(op, 3'd0, imm);
    endtask

    task automatic send_mov_imm(input reg_idx_t r, input word_t imm);
        queue_byte(MOV_IMM_BASE | {5'b0, r});
        queue_byte(imm[7:0]);
        queue_byte(imm[15:8]);
        model_exec(ALU_MOV, r, imm);
    endtask

    // Waits for every queued byte and record, then watches for strays
    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while ((tx_q.size() != 0 || exp_reg.size() != 0) && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_reg.size() != 0) begin
            other_errors++;
            $display("%0d expected results never arrived by %0t", exp_reg.size(), $time);
            tx_q.delete();
            exp_reg.delete();
            exp_value.delete();
            exp_flags.delete();
        end
        repeat (20) @(posedge clk);
    endtask

    task automatic test_mov_imm();
        for (int r = 0; r < 8; r++) begin
            send_mov_imm(reg_idx_t'(r), 16'h1357 + 16'h1111 * 16'(r));
        end
        wait_drain(tx_q.size() * CYCLES_PER_BYTE + 100);
    endtask

    task automatic test_reg_reg();
        send_mov_imm(3'd1, 16'h8000);
        send_mov_imm(3'd2, 16'hFFFF);
        for (int i = 0; i < 7; i++) begin
            for (int dir = 0; dir < 2; dir++) begin
                send_rr(OPS[i], dir[0], reg_idx_t'(i * 3 + dir), reg_idx_t'(i * 5 + 1 + dir));
            end
        end
        send_rr(ALU_SUB, 1'b0, 3'd4, 3'd4);
        send_rr(ALU_XOR, 1'b1, 3'd5, 3'd5);
        wait_drain(tx_q.size() * CYCLES_PER_BYTE + 100);
    endtask

    task automatic test_acc_imm();
        send_mov_imm(3'd0, 16'hFFFF);
        send_acc(ALU_ADD, 16'h0001);
        send_mov_imm(3'd0, 16'h7FFF);
        send_acc(ALU_ADD, 16'h0001);
        send_mov_imm(3'd0, 16'h0000);
        send_acc(ALU_SUB, 16'h0001);
        send_mov_imm(3'd0, 16'h8000);
        send_acc(ALU_SUB, 16'h0001);
        send_acc(ALU_CMP, 16'h7FFF);
        send_acc(ALU_CMP, 16'h8000);
        send_acc(ALU_OR, 16'h8001);
        send_acc(ALU_AND, 16'h00F0);
        send_acc(ALU_XOR, 16'h00F0);
        wait_drain(tx_q.size() * CYCLES_PER_BYTE + 100);
    endtask

    task automatic test_discard();
        send_mov_imm(3'd1, 16'h1234);
        queue_byte(8'h90);
        send_rr(ALU_ADD, 1'b0, 3'd3, 3'd1);
        // Memory operand forms, mod 00, 01 and 10
        queue_byte(8'h01);
        queue_byte(8'h08);
        send_acc(ALU_XOR, 16'h5A5A);
        queue_byte(8'h0F);
        queue_byte(8'h2B);
        queue_byte(8'h4A);
        queue_byte(8'hF4);
        send_rr(ALU_SUB, 1'b1, 3'd6, 3'd3);
        queue_byte(8'h00);
        queue_byte(8'h8B);
        queue_byte(8'h93);
        send_mov_imm(3'd7, 16'hBEEF);
        wait_drain(tx_q.size() * CYCLES_PER_BYTE + 100);
    endtask

    task automatic test_backpressure();
        int unsigned kind;
        sink_random = 1'b1;
        for (int i = 0; i < RAND_INSNS; i++) begin
            kind = $urandom_range(2);
            if (kind == 0) begin
                send_rr(OPS[$urandom_range(6)], $urandom_range(1), reg_idx_t'($urandom_range(7)),
                        reg_idx_t'($urandom_range(7)));
            end else if (kind == 1) begin
                send_acc(OPS[$urandom_range(5)], word_t'($urandom));
            end else begin
                send_mov_imm(reg_idx_t'($urandom_range(7)), word_t'($urandom));
            end
        end
        wait_drain(tx_q.size() * CYCLES_PER_BYTE + 200);
        sink_random = 1'b0;
    endtask

    // Sender side, spends one credit per byte
    initial begin : byte_driver
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && tx_q.size() != 0 && tx_credits > 0) begin
                in_valid = 1'b1;
                in_byte  = tx_q.pop_front();
                tx_credits--;
            end else begin
                in_valid = 1'b0;
            end
        end
    end

    // Sink side, hands slots back either at once or in random bursts
    initial begin : result_sink
        int pause;
        pause = 0;
        forever begin
            @(posedge clk);
            #1;
            if (pause > 0) begin
                pause--;
                res_credit = 1'b0;
            end else if (sink_held > 0) begin
                res_credit = 1'b1;
                sink_held--;
                if (sink_random && $urandom_range(2) == 0) begin
                    pause = $urandom_range(10, 1);
                end
            end else begin
                res_credit = 1'b0;
            end
        end
    end

    // Mid-cycle sampling of credits and results
    initial begin : monitor
        forever begin
            @(negedge clk);
            if (in_credit) begin
                tx_credits++;
                if (tx_credits > BYTE_FIFO_DEPTH) begin
                    other_errors++;
                    $display("byte credit returned beyond the queue depth at %0t", $time);
                end
            end
            if (res_valid) begin
                if (sink_held >= RES_CREDITS) begin
                    other_errors++;
                    $display("result delivered while the sink had no free slot at %0t", $time);
                end
                sink_held++;
                if (exp_reg.size() == 0) begin
                    other_errors++;
                    $display("unexpected extra result for register %0d at %0t", res_reg, $time);
                end else begin
                    compare_reg(res_reg, exp_reg.pop_front());
                    compare_value(res_value, exp_value.pop_front());
                    compare_flags(res_flags, exp_flags.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= bytes_sent * CYCLES_PER_BYTE + WATCHDOG_MARGIN) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        void'($urandom(89));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_byte      = '0;
        res_credit   = 1'b0;
        tx_credits   = BYTE_FIFO_DEPTH;
        sink_held    = 0;
        sink_random  = 1'b0;
        bytes_sent   = 0;
        mismatches   = 0;
        other_errors = 0;
        m_flags      = '0;
        for (int i = 0; i < 8; i++) begin
            m_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_mov_imm();
        test_reg_reg();
        test_acc_imm();
        test_discard();
        test_backpressure();

        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/x86_isa_pkg.sv
rtl/core_uarch_pkg.sv
rtl/credit_fifo.sv
rtl/insn_decode.sv
rtl/alu_execute.sv
rtl/retire_result.sv
rtl/core_top.sv
verification/core_asserts.sv
verification/core_tb.sv

/* Makefile */
# Verilator simulation of the core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
